//--- src.f
+incdir+common
common/BackendPkg.sv
src/DecodeStage.sv
src/CtrlUnitBackend.sv
rename/RenameMap.sv
src/ReorderBuffer.sv
dispatch/IssueQueue.sv
src/BackendTop.sv
bench/BackendChecker.sv
bench/BackendCtrl_assert.sv
bench/BackendTb.sv

//--- run.sh
#!/bin/sh
# Build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module BackendTb -Mdir obj_dir -f src.f

./obj_dir/VBackendTb | tee sim.log

# Exit status follows the pass message in the log
grep -qx "test passed" sim.log

//--- bench/BackendTb.sv
`timescale 1ns/100ps

module BackendTb;
    import BackendPkg::*;

    localparam logic [1:0] PhaseFree = 2'd0;
    localparam logic [1:0] PhaseQueueStall = 2'd1;
    localparam logic [1:0] PhaseRobStall = 2'd2;

    logic     clk, rstN, instValid, instReady, flushReq;
    rawInst_t inst;
    logic     aluValid, aluReady, lsuValid, lsuReady, mduValid, mduReady;
    physReg_t aluTag, lsuTag, mduTag, commitTag;
    payload_t aluPayload, lsuPayload, mduPayload;
    robIdx_t  aluRob, lsuRob, mduRob;
    logic     commitValid, commitReady;
    archReg_t commitDest;
    int       errorCount, pendingCount;

    // Each row holds valid, inst[15:0], aluR, lsuR, mduR, commitR, flush and phase[1:0]
    logic [23:0] stimRows[$];
    rawInst_t    pendingInst[$];
    int          seed, cycleCount, cycleLimit, queueStalls, robStalls, scenarioErrors;
    logic        accepted;

    BackendTop DUT (.*);

    BackendChecker scoreboard (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    function automatic rawInst_t makeInst(input int cls);
        rawInst_t word;
        word = rawInst_t'($random(seed));
        if (cls >= 0) word[15:14] = cls[1:0];
        return word;
    endfunction

    function automatic logic mostlyHigh();
        return (($random(seed) & 3) != 0);
    endfunction

    task automatic addRow(input logic valid, input rawInst_t word, input logic [4:0] ctl,
                          input logic [1:0] phase);
        stimRows.push_back({valid, word, ctl, phase});
    endtask

    task automatic buildTable();
        for (int i = 0; i < 40; i++) begin
            addRow(1'b1, makeInst(-1),
                   {mostlyHigh(), mostlyHigh(), mostlyHigh(), mostlyHigh(), 1'b0}, PhaseFree);
        end
        // LSU queue held closed until it fills
        for (int i = 0; i < 12; i++) addRow(1'b1, makeInst(1), 5'b10110, PhaseQueueStall);
        for (int i = 0; i < 6; i++) addRow(1'b0, '0, 5'b11110, PhaseFree);
        // No commits, so the ROB fills
        for (int i = 0; i < 14; i++) addRow(1'b1, makeInst(0), 5'b11100, PhaseRobStall);
        for (int i = 0; i < 8; i++) addRow(1'b1, makeInst(-1), 5'b11110, PhaseFree);
        for (int i = 0; i < 6; i++) begin
            addRow(1'b1, makeInst(-1),
                   {mostlyHigh(), mostlyHigh(), mostlyHigh(), mostlyHigh(), 1'b0}, PhaseFree);
        end
        addRow(1'b0, '0, 5'b00001, PhaseFree);
        // Long enough to use up the rebuilt free list and reissue the freed old tags
        for (int i = 0; i < 24; i++) begin
            addRow(1'b1, makeInst(-1),
                   {mostlyHigh(), mostlyHigh(), mostlyHigh(), mostlyHigh(), 1'b0}, PhaseFree);
        end
    endtask

    task automatic applyCycle(input logic [23:0] row);
        @(negedge clk);
        if (accepted) void'(pendingInst.pop_front());
        if (row[23]) pendingInst.push_back(row[22:7]);
        aluReady    = row[6];
        lsuReady    = row[5];
        mduReady    = row[4];
        commitReady = row[3];
        flushReq    = row[2];
        instValid   = (pendingInst.size() != 0);
        inst        = instValid ? pendingInst[0] : '0;
        #1;
        accepted = instValid && instReady;
        if (instValid && !instReady && row[1:0] == PhaseQueueStall) queueStalls++;
        if (instValid && !instReady && row[1:0] == PhaseRobStall) robStalls++;
    endtask

    initial begin
        seed           = 83717;
        clk            = 1'b0;
        rstN           = 1'b0;
        instValid      = 1'b0;
        inst           = '0;
        aluReady       = 1'b0;
        lsuReady       = 1'b0;
        mduReady       = 1'b0;
        commitReady    = 1'b0;
        flushReq       = 1'b0;
        accepted       = 1'b0;
        cycleCount     = 0;
        queueStalls    = 0;
        robStalls      = 0;
        scenarioErrors = 0;
        buildTable();
        cycleLimit = stimRows.size() * 4 + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        foreach (stimRows[r]) applyCycle(stimRows[r]);
        // Open everything until all outstanding work has drained
        while (pendingInst.size() != 0 || pendingCount != 0) begin
            applyCycle({1'b0, 16'h0, 5'b11110, PhaseFree});
        end
        if (queueStalls == 0) begin
            $display("A full issue queue never stalled the input port");
            scenarioErrors++;
        end
        if (robStalls == 0) begin
            $display("A full reorder buffer never stalled the input port");
            scenarioErrors++;
        end
        $display("Errors: checker %0d, scenario %0d", errorCount, scenarioErrors);
        if (errorCount == 0 && scenarioErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- bench/BackendCtrl_assert.sv
`timescale 1ns/100ps

module BackendCtrlAssert (
    input logic clk,
    input logic rstN,
    input logic flushReq,
    input logic decodeFlush,
    input logic robFlush,
    input logic renameRecover,
    input logic aluIQFlush,
    input logic lsuIQFlush,
    input logic mduIQFlush,
    input logic aluIQReady,
    input logic lsuIQReady,
    input logic mduIQReady,
    input logic decodePause,
    input logic dispatchFire
);

    flushFanout: assert property (@(posedge clk) disable iff (!rstN)
        {decodeFlush, robFlush, renameRecover, aluIQFlush, lsuIQFlush, mduIQFlush}
            == {6{flushReq}})
        else $error("flush outputs differ from flushReq");

    queueFullPauses: assert property (@(posedge clk) disable iff (!rstN)
        !(aluIQReady && lsuIQReady && mduIQReady) |-> decodePause)
        else $error("a queue is full but decode is not paused");

    noDispatchWhilePaused: assert property (@(posedge clk) disable iff (!rstN)
        decodePause |-> !dispatchFire)
        else $error("dispatch fired while decode was paused");

endmodule

bind BackendTop BackendCtrlAssert ctrlAssert (
    .clk, .rstN, .flushReq, .decodeFlush, .robFlush, .renameRecover,
    .aluIQFlush, .lsuIQFlush, .mduIQFlush, .aluIQReady, .lsuIQReady, .mduIQReady,
    .decodePause, .dispatchFire
);

//--- bench/BackendChecker.sv
`timescale 1ns/100ps
`include "backend_defines.svh"

module BackendChecker (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instValid,
    input  logic                 instReady,
    input  BackendPkg::rawInst_t inst,
    input  logic                 aluValid,
    input  logic                 aluReady,
    input  BackendPkg::physReg_t aluTag,
    input  BackendPkg::payload_t aluPayload,
    input  BackendPkg::robIdx_t  aluRob,
    input  logic                 lsuValid,
    input  logic                 lsuReady,
    input  BackendPkg::physReg_t lsuTag,
    input  BackendPkg::payload_t lsuPayload,
    input  BackendPkg::robIdx_t  lsuRob,
    input  logic                 mduValid,
    input  logic                 mduReady,
    input  BackendPkg::physReg_t mduTag,
    input  BackendPkg::payload_t mduPayload,
    input  BackendPkg::robIdx_t  mduRob,
    input  logic                 commitValid,
    input  logic                 commitReady,
    input  BackendPkg::archReg_t commitDest,
    input  BackendPkg::physReg_t commitTag,
    input  logic                 flushReq,
    output int                   errorCount,
    output int                   pendingCount
);
    import BackendPkg::*;

    // Issue entries are {tag, payload, robIdx}, ROB entries {dest, tag, oldTag}
    logic [17:0] issueQ [3][$];
    logic [13:0] robQ[$];
    physReg_t    freeQ[$];
    physReg_t    specMap   [`ARCH_REGS];
    physReg_t    commitMap [`ARCH_REGS];
    robIdx_t     robTail;
    logic        firstCycle;

    initial errorCount = 0;

    task automatic rebuildFree();
        logic [`PHYS_REGS-1:0] held;
        held = '0;
        freeQ.delete();
        for (int a = 0; a < `ARCH_REGS; a++) begin
            held[commitMap[a]] = 1'b1;
        end
        for (int t = 0; t < `PHYS_REGS; t++) begin
            if (!held[t]) begin
                freeQ.push_back(physReg_t'(t));
            end
        end
    endtask

    task automatic clearInFlight();
        for (int u = 0; u < 3; u++) begin
            issueQ[u].delete();
        end
        robQ.delete();
        robTail = '0;
        for (int a = 0; a < `ARCH_REGS; a++) begin
            specMap[a] = commitMap[a];
        end
        rebuildFree();
    endtask

    task automatic checkIssue(input int unit, input string name, input physReg_t tag,
                              input payload_t payload, input robIdx_t rob);
        logic [17:0] exp;
        if (issueQ[unit].size() == 0) begin
            errorCount++;
            $display("ERROR %0t: %s queue issued tag %0d with nothing outstanding",
                     $time, name, tag);
        end else begin
            exp = issueQ[unit].pop_front();
            if ({tag, payload, rob} !== exp) begin
                errorCount++;
                $display("ERROR %0t: %s issue tag %0d payload %h rob %0d, expected %0d %h %0d",
                         $time, name, tag, payload, rob, exp[17:13], exp[12:3], exp[2:0]);
            end
        end
    endtask

    task automatic retireHead();
        logic [13:0] exp;
        if (robQ.size() == 0) begin
            errorCount++;
            $display("ERROR %0t: commit of dest %0d with no instruction in flight",
                     $time, commitDest);
        end else begin
            exp = robQ.pop_front();
            if ({commitDest, commitTag} !== exp[13:5]) begin
                errorCount++;
                $display("ERROR %0t: commit dest %0d tag %0d, expected dest %0d tag %0d",
                         $time, commitDest, commitTag, exp[13:10], exp[9:5]);
            end
            commitMap[exp[13:10]] = exp[9:5];
            freeQ.push_back(exp[4:0]);
        end
    endtask

    task automatic acceptInst(input rawInst_t word);
        int       unit;
        archReg_t dest;
        physReg_t tag;
        unit = (word[15:14] == 2'd1) ? 1 : (word[15:14] == 2'd2) ? 2 : 0;
        dest = word[13:10];
        if (freeQ.size() == 0) begin
            errorCount++;
            $display("ERROR %0t: free list ran empty at dispatch", $time);
        end else begin
            tag = freeQ.pop_front();
            issueQ[unit].push_back({tag, word[9:0], robTail});
            robQ.push_back({dest, tag, specMap[dest]});
            specMap[dest] = tag;
            robTail = robTail + 1'b1;
        end
    endtask

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                commitMap[a] = physReg_t'(a);
            end
            clearInFlight();
            firstCycle = 1'b1;
        end else begin
            if (firstCycle && (aluValid || lsuValid || mduValid || commitValid || !instReady)) begin
                errorCount++;
                $display("ERROR %0t: outputs not idle right after reset", $time);
            end
            firstCycle = 1'b0;
            if (commitValid && commitReady) retireHead();
            if (aluValid && aluReady) checkIssue(0, "ALU", aluTag, aluPayload, aluRob);
            if (lsuValid && lsuReady) checkIssue(1, "LSU", lsuTag, lsuPayload, lsuRob);
            if (mduValid && mduReady) checkIssue(2, "MDU", mduTag, mduPayload, mduRob);
            if (flushReq) begin
                clearInFlight();
            end else if (instValid && instReady) begin
                acceptInst(inst);
            end
            // The ROB plus the decode register bound what can be in flight
            if (robQ.size() > `ROB_DEPTH + 1) begin
                errorCount++;
                $display("ERROR %0t: %0d instructions in flight", $time, robQ.size());
            end
        end
        pendingCount = robQ.size() + issueQ[0].size() + issueQ[1].size() + issueQ[2].size();
    end

endmodule

//--- src/BackendTop.sv
`timescale 1ns/100ps

module BackendTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instValid,
    output logic                 instReady,
    input  BackendPkg::rawInst_t inst,
    output logic                 aluValid,
    input  logic                 aluReady,
    output BackendPkg::physReg_t aluTag,
    output BackendPkg::payload_t aluPayload,
    output BackendPkg::robIdx_t  aluRob,
    output logic                 lsuValid,
    input  logic                 lsuReady,
    output BackendPkg::physReg_t lsuTag,
    output BackendPkg::payload_t lsuPayload,
    output BackendPkg::robIdx_t  lsuRob,
    output logic                 mduValid,
    input  logic                 mduReady,
    output BackendPkg::physReg_t mduTag,
    output BackendPkg::payload_t mduPayload,
    output BackendPkg::robIdx_t  mduRob,
    output logic                 commitValid,
    input  logic                 commitReady,
    output BackendPkg::archReg_t commitDest,
    output BackendPkg::physReg_t commitTag,
    input  logic                 flushReq
);
    import BackendPkg::*;

    logic       decValid;
    unitClass_t decClass;
    archReg_t   decDest;
    payload_t   decPayload;
    logic       decodePause, renamePause, renameRecover, robFlush, decodeFlush;
    logic       aluIQFlush, lsuIQFlush, mduIQFlush;
    logic       aluIQReady, lsuIQReady, mduIQReady;
    logic       robPauseReq, renameAllocatable;
    logic       dispatchFire, retire;
    physReg_t   newTag, oldTag, freeTag;
    robIdx_t    robIdx;

    // One decoded instruction leaves per cycle once every structure has room
    assign dispatchFire = decValid && !decodePause;
    assign retire       = commitValid && commitReady;

    DecodeStage decode (
        .clk, .rstN, .instValid, .inst,
        .pause(decodePause), .flush(decodeFlush), .instReady,
        .decValid, .decClass, .decDest, .decPayload
    );

    CtrlUnitBackend ctrl (
        .robPauseReq, .aluIQReady, .lsuIQReady, .mduIQReady, .renameAllocatable, .flushReq,
        .decodePause, .renamePause, .renameRecover, .robFlush, .decodeFlush,
        .aluIQFlush, .lsuIQFlush, .mduIQFlush
    );

    RenameMap rename (
        .clk, .rstN, .allocate(dispatchFire), .pause(renamePause), .allocDest(decDest),
        .recover(renameRecover), .commit(retire), .commitDest, .commitTag, .freeTag,
        .allocatable(renameAllocatable), .newTag, .oldTag
    );

    ReorderBuffer rob (
        .clk, .rstN, .push(dispatchFire), .pushDest(decDest), .pushTag(newTag),
        .pushOld(oldTag), .flush(robFlush), .commitReady, .pauseReq(robPauseReq),
        .pushIdx(robIdx), .commitValid, .commitDest, .commitTag, .freeTag
    );

    IssueQueue aluQueue (
        .clk, .rstN, .push(dispatchFire && decClass == UnitAlu), .pushTag(newTag),
        .pushPayload(decPayload), .pushRob(robIdx), .flush(aluIQFlush), .outReady(aluReady),
        .ready(aluIQReady), .outValid(aluValid), .outTag(aluTag), .outPayload(aluPayload),
        .outRob(aluRob)
    );

    IssueQueue lsuQueue (
        .clk, .rstN, .push(dispatchFire && decClass == UnitLsu), .pushTag(newTag),
        .pushPayload(decPayload), .pushRob(robIdx), .flush(lsuIQFlush), .outReady(lsuReady),
        .ready(lsuIQReady), .outValid(lsuValid), .outTag(lsuTag), .outPayload(lsuPayload),
        .outRob(lsuRob)
    );

    IssueQueue mduQueue (
        .clk, .rstN, .push(dispatchFire && decClass == UnitMdu), .pushTag(newTag),
        .pushPayload(decPayload), .pushRob(robIdx), .flush(mduIQFlush), .outReady(mduReady),
        .ready(mduIQReady), .outValid(mduValid), .outTag(mduTag), .outPayload(mduPayload),
        .outRob(mduRob)
    );

endmodule

//--- dispatch/IssueQueue.sv
`timescale 1ns/100ps
`include "backend_defines.svh"

module IssueQueue #(
    parameter int Depth = `IQ_DEPTH
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 push,
    input  BackendPkg::physReg_t pushTag,
    input  BackendPkg::payload_t pushPayload,
    input  BackendPkg::robIdx_t  pushRob,
    input  logic                 flush,
    input  logic                 outReady,
    output logic                 ready,
    output logic                 outValid,
    output BackendPkg::physReg_t outTag,
    output BackendPkg::payload_t outPayload,
    output BackendPkg::robIdx_t  outRob
);
    import BackendPkg::*;

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

    physReg_t               tagMem     [Depth];
    payload_t               payloadMem [Depth];
    robIdx_t                robMem     [Depth];
    logic [PtrW-1:0]        head;
    logic [PtrW-1:0]        tail;
    logic [$clog2(Depth):0] count;
    logic                   pop;

    assign ready    = (count != Depth);
    assign outValid = (count != '0);
    assign pop      = outValid && outReady;

    assign outTag     = tagMem[head];
    assign outPayload = payloadMem[head];
    assign outRob     = robMem[head];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PtrW'(Depth - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PtrW'(Depth - 1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            tagMem[tail]     <= pushTag;
            payloadMem[tail] <= pushPayload;
            robMem[tail]     <= pushRob;
        end
    end

endmodule

//--- src/ReorderBuffer.sv
`timescale 1ns/100ps
`include "backend_defines.svh"

module ReorderBuffer (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 push,
    input  BackendPkg::archReg_t pushDest,
    input  BackendPkg::physReg_t pushTag,
    input  BackendPkg::physReg_t pushOld,
    input  logic                 flush,
    input  logic                 commitReady,
    output logic                 pauseReq,
    output BackendPkg::robIdx_t  pushIdx,
    output logic                 commitValid,
    output BackendPkg::archReg_t commitDest,
    output BackendPkg::physReg_t commitTag,
    output BackendPkg::physReg_t freeTag
);
    import BackendPkg::*;

    localparam int Depth = `ROB_DEPTH;

    archReg_t                destMem [Depth];
    physReg_t                tagMem  [Depth];
    physReg_t                oldMem  [Depth];
    robIdx_t                 head;
    robIdx_t                 tail;
    logic [$clog2(Depth):0]  count;
    logic                    pop;

    assign pauseReq    = (count == Depth);
    assign pushIdx     = tail;
    assign commitValid = (count != '0);
    assign pop         = commitValid && commitReady;

    assign commitDest = destMem[head];
    assign commitTag  = tagMem[head];
    assign freeTag    = oldMem[head];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            destMem[tail] <= pushDest;
            tagMem[tail]  <= pushTag;
            oldMem[tail]  <= pushOld;
        end
    end

endmodule

//--- rename/RenameMap.sv
`timescale 1ns/100ps
`include "backend_defines.svh"

module RenameMap (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 allocate,
    input  logic                 pause,
    input  BackendPkg::archReg_t allocDest,
    input  logic                 recover,
    input  logic                 commit,
    input  BackendPkg::archReg_t commitDest,
    input  BackendPkg::physReg_t commitTag,
    input  BackendPkg::physReg_t freeTag,
    output logic                 allocatable,
    output BackendPkg::physReg_t newTag,
    output BackendPkg::physReg_t oldTag
);
    import BackendPkg::*;

    localparam int FreeDepth = `PHYS_REGS - `ARCH_REGS;
    localparam int FreePtrW  = $clog2(FreeDepth);

    physReg_t              specMap       [`ARCH_REGS];
    physReg_t              commitMap     [`ARCH_REGS];
    physReg_t              commitMapNext [`ARCH_REGS];
    physReg_t              freeList      [FreeDepth];
    physReg_t              rebuildList   [FreeDepth];
    logic [FreePtrW-1:0]   freeHead;
    logic [FreePtrW-1:0]   freeTail;
    logic [FreePtrW:0]     freeCount;
    logic [FreePtrW:0]     rebuildFill;
    logic [`PHYS_REGS-1:0] heldTags;
    logic                  doAlloc;

    assign allocatable = (freeCount != '0);
    assign newTag      = freeList[freeHead];
    assign oldTag      = specMap[allocDest];
    assign doAlloc     = allocate && !pause && allocatable;

    // A commit on the flush cycle already counts toward the recovered state
    always_comb begin
        commitMapNext = commitMap;
        if (commit) begin
            commitMapNext[commitDest] = commitTag;
        end
    end

    // Every tag the committed map does not hold goes back, lowest first
    always_comb begin
        heldTags    = '0;
        rebuildList = '{default: '0};
        rebuildFill = '0;
        for (int a = 0; a < `ARCH_REGS; a++) begin
            heldTags[commitMapNext[a]] = 1'b1;
        end
        for (int t = 0; t < `PHYS_REGS; t++) begin
            if (!heldTags[t] && rebuildFill < FreeDepth) begin
                rebuildList[rebuildFill[FreePtrW-1:0]] = physReg_t'(t);
                rebuildFill = rebuildFill + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                specMap[a]   <= physReg_t'(a);
                commitMap[a] <= physReg_t'(a);
            end
            for (int i = 0; i < FreeDepth; i++) begin
                freeList[i] <= physReg_t'(`ARCH_REGS + i);
            end
            freeHead  <= '0;
            freeTail  <= '0;
            freeCount <= (FreePtrW+1)'(FreeDepth);
        end else begin
            commitMap <= commitMapNext;
            if (recover) begin
                specMap   <= commitMapNext;
                freeList  <= rebuildList;
                freeHead  <= '0;
                freeTail  <= '0;
                freeCount <= rebuildFill;
            end else begin
                if (doAlloc) begin
                    specMap[allocDest] <= newTag;
                    freeHead           <= freeHead + 1'b1;
                end
                // The retired instruction's previous tag rejoins at the tail
                if (commit) begin
                    freeList[freeTail] <= freeTag;
                    freeTail           <= freeTail + 1'b1;
                end
                case ({commit, doAlloc})
                    2'b10:   freeCount <= freeCount + 1'b1;
                    2'b01:   freeCount <= freeCount - 1'b1;
                    default: freeCount <= freeCount;
                endcase
            end
        end
    end

endmodule

//--- src/CtrlUnitBackend.sv
`timescale 1ns/100ps

module CtrlUnitBackend (
    input  logic robPauseReq,
    input  logic aluIQReady,
    input  logic lsuIQReady,
    input  logic mduIQReady,
    input  logic renameAllocatable,
    input  logic flushReq,
    output logic decodePause,
    output logic renamePause,
    output logic renameRecover,
    output logic robFlush,
    output logic decodeFlush,
    output logic aluIQFlush,
    output logic lsuIQFlush,
    output logic mduIQFlush
);

    // Any downstream structure without room holds the decode register
    assign decodePause =
        robPauseReq         ||
        !aluIQReady         ||
        !lsuIQReady         ||
        !mduIQReady         ||
        !renameAllocatable;

    // Rename checks its own free list, so only the other stalls reach it
    assign renamePause =
        robPauseReq         ||
        !aluIQReady         ||
        !lsuIQReady         ||
        !mduIQReady;

    // The commit agent's flush reaches every stage in the same cycle
    assign decodeFlush   = flushReq;
    assign robFlush      = flushReq;
    assign renameRecover = flushReq;
    assign aluIQFlush    = flushReq;
    assign lsuIQFlush    = flushReq;
    assign mduIQFlush    = flushReq;

endmodule

//--- src/DecodeStage.sv
`timescale 1ns/100ps

module DecodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instValid,
    input  BackendPkg::rawInst_t   inst,
    input  logic                   pause,
    input  logic                   flush,
    output logic                   instReady,
    output logic                   decValid,
    output BackendPkg::unitClass_t decClass,
    output BackendPkg::archReg_t   decDest,
    output BackendPkg::payload_t   decPayload
);
    import BackendPkg::*;

    unitClass_t instClass;
    logic       load;

    always_comb begin
        case (inst[15:14])
            2'd1:    instClass = UnitLsu;
            2'd2:    instClass = UnitMdu;
            default: instClass = UnitAlu;
        endcase
    end

    // The register frees up whenever it is empty or its content dispatches this cycle
    // Nothing is taken in while a flush is pending, so no accepted word is dropped
    assign instReady = (!decValid || !pause) && !flush;
    assign load      = instValid && instReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (flush) begin
            decValid <= 1'b0;
        end else if (instReady) begin
            decValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            decClass   <= instClass;
            decDest    <= archReg_t'(inst[13:10]);
            decPayload <= payload_t'(inst[9:0]);
        end
    end

endmodule

//--- common/BackendPkg.sv
`include "backend_defines.svh"

package BackendPkg;

    // Architectural destination index
    typedef logic [$clog2(`ARCH_REGS)-1:0] archReg_t;

    // Physical register tag handed out by the free list
    typedef logic [$clog2(`PHYS_REGS)-1:0] physReg_t;

    // Slot in the reorder buffer
    typedef logic [$clog2(`ROB_DEPTH)-1:0] robIdx_t;

    // Instruction word as it arrives from the front end
    // Class in [15:14], destination in [13:10], payload below
    typedef logic [15:0] rawInst_t;

    // Opaque part of the instruction carried through to issue
    typedef logic [9:0] payload_t;

    // Class code 3 has no unit of its own and decodes as ALU
    typedef enum logic [1:0] {
        UnitAlu = 2'd0,
        UnitLsu = 2'd1,
        UnitMdu = 2'd2
    } unitClass_t;

endpackage

//--- common/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Architectural register file size seen by the instruction set
`define ARCH_REGS 16

// Physical register pool shared by the rename maps and free list
`define PHYS_REGS 32

// Entries in each of the ALU, LSU and MDU issue queues
`define IQ_DEPTH 4

// In-flight instructions tracked between dispatch and commit
`define ROB_DEPTH 8

`endif
